//--- common/axi_rd_pkg.sv
package axi_rd_pkg;

	////////////////////
	// widths
	////////////////////
	localparam int ADDR_W     = 32;
	localparam int DATA_W     = 32;
	localparam int ID_W       = 4;
	localparam int MEM_WORDS  = 256;
	localparam int WORD_IDX_W = 8;

	////////////////////
	// timing
	////////////////////
	// cycles from write acceptance to sram commit
	localparam int WRITE_COMMIT_CYCLES = 4;
	// slave wait states between ar handshake and rvalid
	localparam int READ_WAIT_CYCLES    = 2;

	typedef logic [ADDR_W-1:0]     addr_t;
	typedef logic [DATA_W-1:0]     data_t;
	typedef logic [ID_W-1:0]       id_t;
	typedef logic [WORD_IDX_W-1:0] word_idx_t;

	// master address phase, one-hot
	typedef enum logic [1:0] {
		RADDR_IDLE = 2'b01,
		RADDR_REQ  = 2'b10
	} raddr_state_e;

	// master data phase, one-hot
	typedef enum logic [1:0] {
		RDATA_IDLE     = 2'b01,
		RDATA_TRANSFER = 2'b10
	} rdata_state_e;

	typedef enum logic [2:0] {
		SLV_IDLE    = 3'b001,
		SLV_WAIT    = 3'b010,
		SLV_RESPOND = 3'b100
	} slave_state_e;

endpackage

//--- axi_read_master/axi_read_master.sv
module axi_read_master (
	input  logic              ACLK,
	input  logic              ARESETn,
	// core read port
	input  logic              ren,
	input  axi_rd_pkg::addr_t araddr,
	input  axi_rd_pkg::id_t   arid,
	output logic              raddr_ok,
	output axi_rd_pkg::data_t rdata,
	output axi_rd_pkg::id_t   rid,
	output logic              rdata_ok,
	// pending write from the commit buffer
	input  logic              writing,
	input  axi_rd_pkg::addr_t pending_addr,
	// axi read address channel
	output axi_rd_pkg::addr_t araddr_axi,
	output axi_rd_pkg::id_t   arid_axi,
	output logic              arvalid,
	input  logic              arready,
	// axi read data channel
	input  axi_rd_pkg::data_t rdata_axi,
	input  axi_rd_pkg::id_t   rid_axi,
	input  logic              rlast,
	input  logic              rvalid,
	output logic              rready
);
	import axi_rd_pkg::*;

	raddr_state_e raddr_state;
	raddr_state_e raddr_state_nxt;
	rdata_state_e rdata_state;
	rdata_state_e rdata_state_nxt;

	logic arvalid_q;
	logic hazard;
	logic req_accept;
	logic ar_hs;
	logic r_last_hs;

	////////////////////
	// handshakes
	////////////////////
	// new request only when both phases are idle
	assign raddr_ok   = ren && (raddr_state == RADDR_IDLE) && (rdata_state == RDATA_IDLE);
	assign req_accept = raddr_ok;

	assign ar_hs     = arvalid && arready;
	assign r_last_hs = rvalid && rready && rlast;

	// hold back arvalid while a write to the same word waits for commit
	assign hazard  = writing && (pending_addr[ADDR_W-1:2] == araddr_axi[ADDR_W-1:2]);
	assign arvalid = arvalid_q && !hazard;

	////////////////////
	// state machines
	////////////////////
	always_ff @(posedge ACLK) begin
		if (!ARESETn) begin
			raddr_state <= RADDR_IDLE;
			rdata_state <= RDATA_IDLE;
		end else begin
			raddr_state <= raddr_state_nxt;
			rdata_state <= rdata_state_nxt;
		end
	end

	// address phase
	always_comb begin
		raddr_state_nxt = raddr_state;
		case (raddr_state)
			RADDR_IDLE: begin
				if (req_accept) begin
					raddr_state_nxt = RADDR_REQ;
				end
			end
			RADDR_REQ: begin
				if (ar_hs) begin
					raddr_state_nxt = RADDR_IDLE;
				end
			end
			default: raddr_state_nxt = RADDR_IDLE;
		endcase
	end

	// data phase, single beat only
	always_comb begin
		rdata_state_nxt = rdata_state;
		case (rdata_state)
			RDATA_IDLE: begin
				if (ar_hs) begin
					rdata_state_nxt = RDATA_TRANSFER;
				end
			end
			RDATA_TRANSFER: begin
				if (r_last_hs) begin
					rdata_state_nxt = RDATA_IDLE;
				end
			end
			default: rdata_state_nxt = RDATA_IDLE;
		endcase
	end

	////////////////////
	// channel control
	////////////////////
	always_ff @(posedge ACLK) begin
		if (!ARESETn) begin
			arvalid_q <= 1'b0;
			rready    <= 1'b0;
			rdata_ok  <= 1'b0;
		end else begin
			if (req_accept) begin
				arvalid_q <= 1'b1;
			end else if (ar_hs) begin
				arvalid_q <= 1'b0;
			end
			if (ar_hs) begin
				rready <= 1'b1;
			end else if (r_last_hs) begin
				rready <= 1'b0;
			end
			rdata_ok <= r_last_hs;
		end
	end

	// request payload, held until the ar handshake
	always_ff @(posedge ACLK) begin
		if (req_accept) begin
			araddr_axi <= araddr;
			arid_axi   <= arid;
		end
	end

	// last beat back to the core
	always_ff @(posedge ACLK) begin
		if (r_last_hs) begin
			rdata <= rdata_axi;
			rid   <= rid_axi;
		end
	end

	ar_payload_stable: assert property (@(posedge ACLK) disable iff (!ARESETn)
		arvalid && !arready |=> arvalid && $stable(araddr_axi) && $stable(arid_axi));

	rdata_ok_single_pulse: assert property (@(posedge ACLK) disable iff (!ARESETn)
		rdata_ok |=> !rdata_ok);

endmodule

//--- source/write_commit_buffer.sv
module write_commit_buffer (
	input  logic                    ACLK,
	input  logic                    ARESETn,
	// core write port
	input  logic                    wen,
	input  axi_rd_pkg::addr_t       waddr,
	input  axi_rd_pkg::data_t       wdata,
	output logic                    wready,
	// hazard info for the read master
	output logic                    writing,
	output axi_rd_pkg::addr_t       pending_addr,
	// commit into the sram
	output logic                    commit_en,
	output axi_rd_pkg::word_idx_t   commit_idx,
	output axi_rd_pkg::data_t       commit_data
);
	import axi_rd_pkg::*;

	logic [$clog2(WRITE_COMMIT_CYCLES+1)-1:0] commit_cnt;
	data_t data_q;
	logic  accept;

	// one entry, so no new write until the commit is done
	assign wready = wen && !writing;
	assign accept = wready;

	////////////////////
	// commit countdown
	////////////////////
	always_ff @(posedge ACLK) begin
		if (!ARESETn) begin
			writing    <= 1'b0;
			commit_en  <= 1'b0;
			commit_cnt <= '0;
		end else if (accept) begin
			writing    <= 1'b1;
			commit_cnt <= $bits(commit_cnt)'(WRITE_COMMIT_CYCLES - 1);
		end else if (commit_en) begin
			// sram takes the word on this edge
			writing   <= 1'b0;
			commit_en <= 1'b0;
		end else if (writing) begin
			if (commit_cnt == '0) begin
				commit_en <= 1'b1;
			end else begin
				commit_cnt <= commit_cnt - 1'b1;
			end
		end
	end

	// held write
	always_ff @(posedge ACLK) begin
		if (accept) begin
			pending_addr <= waddr;
			data_q       <= wdata;
		end
	end

	// byte address to word index
	assign commit_idx  = pending_addr[WORD_IDX_W+1:2];
	assign commit_data = data_q;

	commit_inside_write: assert property (@(posedge ACLK) disable iff (!ARESETn)
		$rose(commit_en) |-> writing && $past(writing));

endmodule

//--- source/axi_sram_slave.sv
module axi_sram_slave (
	input  logic                  ACLK,
	input  logic                  ARESETn,
	// axi read address channel
	input  axi_rd_pkg::addr_t     araddr_axi,
	input  axi_rd_pkg::id_t       arid_axi,
	input  logic                  arvalid,
	output logic                  arready,
	// axi read data channel
	output axi_rd_pkg::data_t     rdata_axi,
	output axi_rd_pkg::id_t       rid_axi,
	output logic                  rlast,
	output logic                  rvalid,
	input  logic                  rready,
	// commit port from the write buffer
	input  logic                  commit_en,
	input  axi_rd_pkg::word_idx_t commit_idx,
	input  axi_rd_pkg::data_t     commit_data
);
	import axi_rd_pkg::*;

	data_t mem [MEM_WORDS];

	slave_state_e state;
	word_idx_t    idx_q;
	logic [$clog2(READ_WAIT_CYCLES+1)-1:0] wait_cnt;
	logic ar_hs;
	logic wait_done;

	assign arready   = (state == SLV_IDLE);
	assign ar_hs     = arvalid && arready;
	assign wait_done = (state == SLV_WAIT) && (wait_cnt == '0);

	// single beat, so every beat is the last
	assign rvalid = (state == SLV_RESPOND);
	assign rlast  = rvalid;

	////////////////////
	// read fsm
	////////////////////
	always_ff @(posedge ACLK) begin
		if (!ARESETn) begin
			state    <= SLV_IDLE;
			wait_cnt <= '0;
		end else begin
			case (state)
				SLV_IDLE: begin
					if (ar_hs) begin
						state    <= SLV_WAIT;
						wait_cnt <= $bits(wait_cnt)'(READ_WAIT_CYCLES - 1);
					end
				end
				SLV_WAIT: begin
					if (wait_cnt == '0) begin
						state <= SLV_RESPOND;
					end else begin
						wait_cnt <= wait_cnt - 1'b1;
					end
				end
				SLV_RESPOND: begin
					if (rready) begin
						state <= SLV_IDLE;
					end
				end
				default: state <= SLV_IDLE;
			endcase
		end
	end

	// address and id latch
	always_ff @(posedge ACLK) begin
		if (ar_hs) begin
			idx_q   <= araddr_axi[WORD_IDX_W+1:2];
			rid_axi <= arid_axi;
		end
	end

	// array read at the end of the wait states
	always_ff @(posedge ACLK) begin
		if (wait_done) begin
			rdata_axi <= mem[idx_q];
		end
	end

	// commits land in any state
	always_ff @(posedge ACLK) begin
		if (commit_en) begin
			mem[commit_idx] <= commit_data;
		end
	end

	rvalid_held: assert property (@(posedge ACLK) disable iff (!ARESETn)
		rvalid && !rready |=> rvalid && $stable(rdata_axi) && $stable(rid_axi));

endmodule

//--- source/axi_read_subsystem.sv
module axi_read_subsystem (
	input  logic              ACLK,
	input  logic              ARESETn,
	// core read port
	input  logic              ren,
	input  axi_rd_pkg::addr_t araddr,
	input  axi_rd_pkg::id_t   arid,
	output logic              raddr_ok,
	output axi_rd_pkg::data_t rdata,
	output axi_rd_pkg::id_t   rid,
	output logic              rdata_ok,
	// core write port
	input  logic              wen,
	input  axi_rd_pkg::addr_t waddr,
	input  axi_rd_pkg::data_t wdata,
	output logic              wready
);
	import axi_rd_pkg::*;

	////////////////////
	// internal axi read channel
	////////////////////
	addr_t araddr_axi;
	id_t   arid_axi;
	logic  arvalid;
	logic  arready;
	data_t rdata_axi;
	id_t   rid_axi;
	logic  rlast;
	logic  rvalid;
	logic  rready;

	// write buffer to master and slave
	logic      writing;
	addr_t     pending_addr;
	logic      commit_en;
	word_idx_t commit_idx;
	data_t     commit_data;

	axi_read_master i_axi_read_master (
		.ACLK         (ACLK),
		.ARESETn      (ARESETn),
		.ren          (ren),
		.araddr       (araddr),
		.arid         (arid),
		.raddr_ok     (raddr_ok),
		.rdata        (rdata),
		.rid          (rid),
		.rdata_ok     (rdata_ok),
		.writing      (writing),
		.pending_addr (pending_addr),
		.araddr_axi   (araddr_axi),
		.arid_axi     (arid_axi),
		.arvalid      (arvalid),
		.arready      (arready),
		.rdata_axi    (rdata_axi),
		.rid_axi      (rid_axi),
		.rlast        (rlast),
		.rvalid       (rvalid),
		.rready       (rready)
	);

	write_commit_buffer i_write_commit_buffer (
		.ACLK         (ACLK),
		.ARESETn      (ARESETn),
		.wen          (wen),
		.waddr        (waddr),
		.wdata        (wdata),
		.wready       (wready),
		.writing      (writing),
		.pending_addr (pending_addr),
		.commit_en    (commit_en),
		.commit_idx   (commit_idx),
		.commit_data  (commit_data)
	);

	axi_sram_slave i_axi_sram_slave (
		.ACLK        (ACLK),
		.ARESETn     (ARESETn),
		.araddr_axi  (araddr_axi),
		.arid_axi    (arid_axi),
		.arvalid     (arvalid),
		.arready     (arready),
		.rdata_axi   (rdata_axi),
		.rid_axi     (rid_axi),
		.rlast       (rlast),
		.rvalid      (rvalid),
		.rready      (rready),
		.commit_en   (commit_en),
		.commit_idx  (commit_idx),
		.commit_data (commit_data)
	);

endmodule

//--- tests/tb_axi_read_subsystem.sv
module tb_axi_read_subsystem;
	timeunit 1ns;
	timeprecision 100ps;

	import axi_rd_pkg::*;

	localparam int READ_LATENCY = READ_WAIT_CYCLES + 3;

	typedef struct packed {
		id_t   id;
		data_t data;
		int    cyc;
		bit    stalled;
	} read_exp_t;

	logic  ACLK = 1'b0;
	logic  ARESETn;
	logic  ren;
	addr_t araddr;
	id_t   arid;
	logic  raddr_ok;
	data_t rdata;
	id_t   rid;
	logic  rdata_ok;
	logic  wen;
	addr_t waddr;
	data_t wdata;
	logic  wready;

	// golden file, one entry per operation
	logic [7:0] op_q[$];
	addr_t      addr_q[$];
	id_t        id_q[$];
	data_t      data_q[$];

	data_t     exp_rdata_drv;
	read_exp_t exp_q[$];

	int    cycle = 0;
	int    cycle_limit = 0;
	int    n_reads = 0;
	int    n_writes = 0;
	int    reads_accepted = 0;
	int    writes_accepted = 0;
	int    responses = 0;
	int    data_errors = 0;
	int    id_errors = 0;
	int    timing_errors = 0;
	int    protocol_errors = 0;
	int    file_errors = 0;
	int    wr_block = 0;
	bit    have_write = 1'b0;
	int    last_write_cyc = 0;
	addr_t last_write_addr = '0;

	axi_read_subsystem i_axi_read_subsystem (
		.ACLK     (ACLK),
		.ARESETn  (ARESETn),
		.ren      (ren),
		.araddr   (araddr),
		.arid     (arid),
		.raddr_ok (raddr_ok),
		.rdata    (rdata),
		.rid      (rid),
		.rdata_ok (rdata_ok),
		.wen      (wen),
		.waddr    (waddr),
		.wdata    (wdata),
		.wready   (wready)
	);

	always #50 ACLK = ~ACLK;

	////////////////////
	// compare tasks
	////////////////////
	task automatic check_data(input string name, input data_t exp, input data_t act);
		if (act !== exp) begin
			data_errors++;
			$display("CHECK FAILED t=%0t %s expected %h actual %h", $time, name, exp, act);
		end
	endtask

	task automatic check_id(input string name, input id_t exp, input id_t act);
		if (act !== exp) begin
			id_errors++;
			$display("CHECK FAILED t=%0t %s expected %h actual %h", $time, name, exp, act);
		end
	endtask

	task automatic check_cycles(input string name, input int exp, input int act);
		if (act != exp) begin
			timing_errors++;
			$display("CHECK FAILED t=%0t %s expected %0d actual %0d", $time, name, exp, act);
		end
	endtask

	////////////////////
	// golden file
	////////////////////
	// shadow memory only cross-checks the expected read values
	task automatic load_golden();
		int               fd;
		int               code;
		logic [7:0]       ch;
		logic [8*200-1:0] skip;
		addr_t            a;
		id_t              i;
		data_t            d;
		word_idx_t        w;
		data_t            shadow [MEM_WORDS];
		bit               shadow_ok [MEM_WORDS];
		fd = $fopen("tests/golden_reads.txt", "r");
		if (fd == 0) begin
			file_errors++;
			$display("could not open tests/golden_reads.txt");
			return;
		end
		while (1) begin
			code = $fscanf(fd, " %c", ch);
			if (code != 1) begin
				break;
			end
			if (ch == "#") begin
				code = $fgets(skip, fd);
				continue;
			end
			code = $fscanf(fd, "%h %h %h", a, i, d);
			if (code != 3) begin
				file_errors++;
				$display("golden file line %0d is malformed", op_q.size() + 1);
				break;
			end
			w = a[WORD_IDX_W+1:2];
			if (a[1:0] != 2'b00 || a >= addr_t'(MEM_WORDS * 4)) begin
				file_errors++;
				$display("golden address %h is unaligned or outside the SRAM", a);
			end
			if (ch == "W") begin
				n_writes++;
				shadow[w] = d;
				shadow_ok[w] = 1'b1;
			end else if (ch == "R") begin
				n_reads++;
				if (!shadow_ok[w] || shadow[w] !== d) begin
					file_errors++;
					$display("golden read of %h expects %h, which is not the last write", a, d);
				end
			end else if (ch != "I") begin
				file_errors++;
				$display("golden file has an unknown opcode %c", ch);
			end
			op_q.push_back(ch);
			addr_q.push_back(a);
			id_q.push_back(i);
			data_q.push_back(d);
		end
		$fclose(fd);
	endtask

	////////////////////
	// drivers
	////////////////////
	// each starts and returns 1 ns after a rising edge
	task automatic write_word(input addr_t a, input data_t d);
		wen   = 1'b1;
		waddr = a;
		wdata = d;
		@(negedge ACLK);
		while (!wready) begin
			@(negedge ACLK);
		end
		@(posedge ACLK);
		#1;
		wen = 1'b0;
	endtask

	// no wait for the response, so the next request is held by raddr_ok
	task automatic read_word(input addr_t a, input id_t i, input data_t d);
		ren           = 1'b1;
		araddr        = a;
		arid          = i;
		exp_rdata_drv = d;
		@(negedge ACLK);
		while (!raddr_ok) begin
			@(negedge ACLK);
		end
		@(posedge ACLK);
		#1;
		ren = 1'b0;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(posedge ACLK);
		#1;
	endtask

	////////////////////
	// monitor, sampled mid-cycle
	////////////////////
	always @(negedge ACLK) begin
		read_exp_t ent;
		int        lat;
		cycle++;
		if (ARESETn) begin
			// one write entry, busy until its commit
			if (wr_block > 0) begin
				if (wready) begin
					protocol_errors++;
					$display("t=%0t wready rose before the pending write committed", $time);
				end
				wr_block--;
			end else if (wen && !wready) begin
				protocol_errors++;
				$display("t=%0t wready stayed low with no write pending", $time);
			end
			if (wen && wready) begin
				wr_block        = WRITE_COMMIT_CYCLES + 1;
				have_write      = 1'b1;
				last_write_cyc  = cycle;
				last_write_addr = waddr;
				writes_accepted++;
			end
			if (rdata_ok) begin
				if (exp_q.size() == 0) begin
					protocol_errors++;
					$display("t=%0t rdata_ok pulsed with no read outstanding", $time);
				end else begin
					ent = exp_q.pop_front();
					lat = cycle - ent.cyc;
					check_id("rid", ent.id, rid);
					check_data("rdata", ent.data, rdata);
					if (!ent.stalled) begin
						check_cycles("read latency", READ_LATENCY, lat);
					end else if (lat <= READ_LATENCY) begin
						timing_errors++;
						$display("t=%0t read behind a pending write was not held back", $time);
					end
					responses++;
				end
			end else if (exp_q.size() != 0 && raddr_ok) begin
				protocol_errors++;
				$display("t=%0t raddr_ok high while a read is outstanding", $time);
			end
			// a pending write to the same word holds the read back
			if (ren && raddr_ok) begin
				ent.id      = arid;
				ent.data    = exp_rdata_drv;
				ent.cyc     = cycle;
				ent.stalled = have_write && (cycle - last_write_cyc <= WRITE_COMMIT_CYCLES)
					&& (last_write_addr[ADDR_W-1:2] == araddr[ADDR_W-1:2]);
				exp_q.push_back(ent);
				reads_accepted++;
			end
		end
	end

	initial begin
		wait (cycle_limit > 0);
		repeat (cycle_limit) @(posedge ACLK);
		$display("simulation hung, still running after %0d cycles", cycle_limit);
		$display("RESULT: FAIL");
		$finish;
	end

	initial begin
		int total;
		ARESETn       = 1'b0;
		ren           = 1'b0;
		araddr        = '0;
		arid          = '0;
		wen           = 1'b0;
		waddr         = '0;
		wdata         = '0;
		exp_rdata_drv = '0;
		load_golden();
		cycle_limit = op_q.size() * (WRITE_COMMIT_CYCLES + READ_WAIT_CYCLES + 8) + 100;
		repeat (16) @(posedge ACLK);
		#1;
		ARESETn = 1'b1;
		if (file_errors == 0) begin
			foreach (op_q[k]) begin
				case (op_q[k])
					"W": write_word(addr_q[k], data_q[k]);
					"R": read_word(addr_q[k], id_q[k], data_q[k]);
					default: idle_cycles(int'(data_q[k]));
				endcase
			end
		end
		while (exp_q.size() != 0) begin
			@(negedge ACLK);
		end
		repeat (WRITE_COMMIT_CYCLES + 2) @(posedge ACLK);
		if (reads_accepted != n_reads || responses != n_reads) begin
			protocol_errors++;
			$display("%0d reads in the file, %0d accepted, %0d answered",
				n_reads, reads_accepted, responses);
		end
		if (writes_accepted != n_writes) begin
			protocol_errors++;
			$display("%0d writes in the file, %0d accepted", n_writes, writes_accepted);
		end
		total = data_errors + id_errors + timing_errors + protocol_errors + file_errors;
		$display("errors: data %0d, id %0d, timing %0d, protocol %0d, golden file %0d",
			data_errors, id_errors, timing_errors, protocol_errors, file_errors);
		if (total == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

//--- tests/golden_reads.txt
# op addr id data: W writes data, R expects data back with id
# I idles for data cycles, addr and id unused
W 00000000 0 11111111
W 00000004 0 22222222
W 00000008 0 33333333
R 00000000 1 11111111
R 00000004 2 22222222
I 00000000 0 00000006
R 00000008 3 33333333
W 00000010 0 deadbeef
R 00000010 4 deadbeef
W 00000010 0 cafef00d
R 00000010 5 cafef00d
R 00000010 6 cafef00d
W 000003fc 0 a5a5a5a5
R 00000004 7 22222222
R 000003fc 8 a5a5a5a5
I 00000000 0 00000003
W 00000020 0 01234567
W 00000020 0 89abcdef
R 00000020 9 89abcdef
W 00000024 0 0f0f0f0f
R 00000000 a 11111111
R 00000024 b 0f0f0f0f
W 00000000 0 76543210
R 00000000 c 76543210
R 00000020 d 89abcdef
W 00000004 0 fedcba98
R 00000004 e fedcba98
R 00000008 f 33333333

//--- verilog.f
common/axi_rd_pkg.sv
axi_read_master/axi_read_master.sv
source/write_commit_buffer.sv
source/axi_sram_slave.sv
source/axi_read_subsystem.sv
tests/tb_axi_read_subsystem.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build with verilator, run, and decide from the log
set -e
set -o pipefail
cd "$(dirname "$0")"
verilator --binary --timing --assert -f verilog.f --top-module tb_axi_read_subsystem \
	-Mdir obj_dir -o sim_tb
./obj_dir/sim_tb | tee sim.log
if grep -q "RESULT: PASS" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
